/* hw/aluPkg.sv */
package aluPkg;

    // operation codes as issued by decode
    typedef enum logic [7:0] {
        OP_NOP,
        OP_AND,
        OP_OR,
        OP_NOR,
        OP_XOR,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_SLLV,
        OP_SRLV,
        OP_SRAV,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_CLO,
        OP_CLZ,
        OP_MOVN,
        OP_MOVZ,
        OP_MULT,
        OP_MULTU,
        OP_MUL,
        OP_MADD,
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        OP_DIV,
        OP_DIVU,
        OP_MTHI,
        OP_MTLO,
        OP_MFHI,
        OP_MFLO,
        OP_TEQ,
        OP_TNE,
        OP_TGE,
        OP_TGEU,
        OP_TLT,
        OP_TLTU
    } aluOp_e;

    // one issued operation
    typedef struct packed {
        aluOp_e      op;
        logic [31:0] srcA;
        logic [31:0] srcB;
        logic [4:0]  sa;
    } execReq_t;

    // single-cycle outcome
    typedef struct packed {
        logic [31:0] result;
        logic        overflow;
        logic        trap;
    } execResp_t;

    // HI/LO write request
    typedef struct packed {
        logic        wrHi;
        logic        wrLo;
        logic [63:0] value;
    } hiLoWr_t;

endpackage

/* hw/execUnit.sv */
module execUnit import aluPkg::*; #(
    parameter int unsigned MUL_LATENCY = 3
) (
    input  logic      clk,
    input  logic      rst_i,
    input  execReq_t  req_i,
    input  logic      flush_i,
    input  logic      flushExc_i,
    output execResp_t resp_o,
    output logic      stall_o
);

    logic [63:0] hiLo;
    logic [31:0] mulLow;
    logic        mulReady;
    hiLoWr_t     hiLoWr;

    intAlu intAlu0 (
        .req_i      (req_i),
        .hiLo_i     (hiLo),
        .mulLow_i   (mulLow),
        .mulReady_i (mulReady),
        .resp_o     (resp_o)
    );

    // multiply and divide sequencing with the HI/LO write path
    mulDivCtrl #(
        .MUL_LATENCY(MUL_LATENCY)
    ) mulDivCtrl0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .hiLo_i     (hiLo),
        .flush_i    (flush_i),
        .flushExc_i (flushExc_i),
        .hiLoWr_o   (hiLoWr),
        .mulLow_o   (mulLow),
        .mulReady_o (mulReady),
        .stall_o    (stall_o)
    );

    hiLoReg hiLoReg0 (
        .clk    (clk),
        .rst_i  (rst_i),
        .wr_i   (hiLoWr),
        .hiLo_o (hiLo)
    );

endmodule

/* hw/hiLoReg.sv */
module hiLoReg import aluPkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  hiLoWr_t     wr_i,
    output logic [63:0] hiLo_o
);

    logic [31:0] hiReg;
    logic [31:0] loReg;

    // each half has its own strobe
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hiReg <= 32'd0;
            loReg <= 32'd0;
        end else begin
            if (wr_i.wrHi) begin
                hiReg <= wr_i.value[63:32];
            end
            if (wr_i.wrLo) begin
                loReg <= wr_i.value[31:0];
            end
        end
    end

    assign hiLo_o = {hiReg, loReg};

endmodule

/* hw/intAlu.sv */
module intAlu import aluPkg::*; (
    input  execReq_t    req_i,
    input  logic [63:0] hiLo_i,
    input  logic [31:0] mulLow_i,
    input  logic        mulReady_i,
    output execResp_t   resp_o
);

    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] result;
    logic        overflow;
    logic        trap;

    // number of zero bits above the highest set bit, 32 when none is set
    function automatic logic [31:0] leadZeros(input logic [31:0] value);
        logic [31:0] count;
        logic        found;
        count = 32'd0;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!found) begin
                if (value[i]) begin
                    found = 1'b1;
                end else begin
                    count = count + 32'd1;
                end
            end
        end
        return count;
    endfunction

    assign srcA = req_i.srcA;
    assign srcB = req_i.srcB;
    assign sum  = srcA + srcB;
    assign diff = srcA - srcB;

    always_comb begin
        result   = 32'd0;
        overflow = 1'b0;
        case (req_i.op)
            OP_NOP:  result = srcA;
            OP_AND:  result = srcA & srcB;
            OP_OR:   result = srcA | srcB;
            OP_NOR:  result = ~(srcA | srcB);
            OP_XOR:  result = srcA ^ srcB;
            OP_ADD: begin
                result   = sum;
                // same operand signs but a different result sign
                overflow = (srcA[31] == srcB[31]) && (sum[31] != srcA[31]);
            end
            OP_ADDU: result = sum;
            OP_SUB: begin
                result   = diff;
                overflow = (srcA[31] != srcB[31]) && (diff[31] != srcA[31]);
            end
            OP_SUBU: result = diff;
            OP_SLT:  result = {31'd0, $signed(srcA) < $signed(srcB)};
            OP_SLTU: result = {31'd0, srcA < srcB};
            // variable shifts take the amount from srcA
            OP_SLLV: result = srcB << srcA[4:0];
            OP_SRLV: result = srcB >> srcA[4:0];
            OP_SRAV: result = $signed(srcB) >>> srcA[4:0];
            OP_SLL:  result = srcB << req_i.sa;
            OP_SRL:  result = srcB >> req_i.sa;
            OP_SRA:  result = $signed(srcB) >>> req_i.sa;
            OP_LUI:  result = {srcB[15:0], 16'd0};
            OP_CLO:  result = leadZeros(~srcA);
            OP_CLZ:  result = leadZeros(srcA);
            OP_MOVN: result = (srcB != 32'd0) ? srcA : 32'd0;
            OP_MOVZ: result = (srcB == 32'd0) ? srcA : 32'd0;
            // low product word only while the multiplier reports ready
            OP_MUL:  result = mulReady_i ? mulLow_i : 32'd0;
            OP_MFHI: result = hiLo_i[63:32];
            OP_MFLO: result = hiLo_i[31:0];
            default: result = 32'd0;
        endcase
    end

    // trap compare
    always_comb begin
        case (req_i.op)
            OP_TEQ:  trap = (srcA == srcB);
            OP_TNE:  trap = (srcA != srcB);
            OP_TGE:  trap = ($signed(srcA) >= $signed(srcB));
            OP_TGEU: trap = (srcA >= srcB);
            OP_TLT:  trap = ($signed(srcA) < $signed(srcB));
            OP_TLTU: trap = (srcA < srcB);
            default: trap = 1'b0;
        endcase
    end

    assign resp_o.result   = result;
    assign resp_o.overflow = overflow;
    assign resp_o.trap     = trap;

endmodule

/* hw/mulDivCtrl.sv */
module mulDivCtrl import aluPkg::*; #(
    parameter int unsigned MUL_LATENCY = 3
) (
    input  logic        clk,
    input  logic        rst_i,
    input  execReq_t    req_i,
    input  logic [63:0] hiLo_i,
    input  logic        flush_i,
    input  logic        flushExc_i,
    output hiLoWr_t     hiLoWr_o,
    output logic [31:0] mulLow_o,
    output logic        mulReady_o,
    output logic        stall_o
);

    logic        isMul;
    logic        isDiv;
    logic        mulSigned;
    logic        divSigned;
    logic        mulStart;
    logic        divStart;
    logic        mulReady;
    logic        divReady;
    logic [63:0] mulResult;
    logic [63:0] divResult;

    // operation class and signedness
    always_comb begin
        isMul     = 1'b0;
        isDiv     = 1'b0;
        mulSigned = 1'b0;
        divSigned = 1'b0;
        case (req_i.op)
            OP_MULT, OP_MUL, OP_MADD, OP_MSUB: begin
                isMul     = 1'b1;
                mulSigned = 1'b1;
            end
            OP_MULTU, OP_MADDU, OP_MSUBU: isMul = 1'b1;
            OP_DIV: begin
                isDiv     = 1'b1;
                divSigned = 1'b1;
            end
            OP_DIVU: isDiv = 1'b1;
            default: ;
        endcase
    end

    // start is a level that drops in the ready cycle
    assign mulStart = isMul && !mulReady;
    assign divStart = isDiv && !divReady;
    assign stall_o  = mulStart || divStart;

    seqMultiplier #(
        .MUL_LATENCY(MUL_LATENCY)
    ) multiplier0 (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (flush_i),
        .start_i  (mulStart),
        .signed_i (mulSigned),
        .opA_i    (req_i.srcA),
        .opB_i    (req_i.srcB),
        .ready_o  (mulReady),
        .result_o (mulResult)
    );

    seqDivider divider0 (
        .clk        (clk),
        .rst_i      (rst_i),
        .flush_i    (flush_i),
        .start_i    (divStart),
        .signed_i   (divSigned),
        .dividend_i (req_i.srcA),
        .divisor_i  (req_i.srcB),
        .ready_o    (divReady),
        .result_o   (divResult)
    );

    // HI/LO write value and strobes
    always_comb begin
        hiLoWr_o.wrHi  = 1'b0;
        hiLoWr_o.wrLo  = 1'b0;
        hiLoWr_o.value = 64'd0;
        case (req_i.op)
            OP_MULT, OP_MULTU, OP_MUL: hiLoWr_o.value = mulResult;
            OP_MADD, OP_MADDU:         hiLoWr_o.value = hiLo_i + mulResult;
            OP_MSUB, OP_MSUBU:         hiLoWr_o.value = hiLo_i - mulResult;
            OP_DIV, OP_DIVU:           hiLoWr_o.value = divResult;
            OP_MTHI:                   hiLoWr_o.value = {req_i.srcA, 32'd0};
            OP_MTLO:                   hiLoWr_o.value = {32'd0, req_i.srcA};
            default: ;
        endcase
        if ((isMul && mulReady) || (isDiv && divReady)) begin
            hiLoWr_o.wrHi = !flushExc_i;
            hiLoWr_o.wrLo = !flushExc_i;
        end
        if (req_i.op == OP_MTHI) begin
            hiLoWr_o.wrHi = !flushExc_i;
        end
        if (req_i.op == OP_MTLO) begin
            hiLoWr_o.wrLo = !flushExc_i;
        end
    end

    assign mulLow_o   = mulResult[31:0];
    assign mulReady_o = mulReady;

endmodule

/* hw/seqDivider.sv */
module seqDivider (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        start_i,
    input  logic        signed_i,
    input  logic [31:0] dividend_i,
    input  logic [31:0] divisor_i,
    output logic        ready_o,
    output logic [63:0] result_o
);

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        FIX
    } divState_e;

    divState_e   state;
    logic [4:0]  stepCount;
    logic [31:0] remReg;
    logic [31:0] quoReg;
    logic [31:0] divisorReg;
    logic        negQuo;
    logic        negRem;
    logic [32:0] trial;
    logic [32:0] trialDiff;

    // next partial remainder with the top quotient bit shifted in
    assign trial     = {remReg, quoReg[31]};
    assign trialDiff = trial - {1'b0, divisorReg};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            state     <= IDLE;
            stepCount <= 5'd0;
            ready_o   <= 1'b0;
        end else begin
            ready_o <= (state == FIX);
            case (state)
                IDLE: begin
                    stepCount <= 5'd0;
                    if (start_i) begin
                        state <= CALC;
                    end
                end
                CALC: begin
                    stepCount <= stepCount + 5'd1;
                    if (stepCount == 5'd31) begin
                        state <= FIX;
                    end
                end
                FIX: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                // load magnitudes and remember the result signs
                remReg     <= 32'd0;
                quoReg     <= (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
                divisorReg <= (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;
                negQuo     <= signed_i && (dividend_i[31] ^ divisor_i[31]);
                negRem     <= signed_i && dividend_i[31];
            end
            CALC: begin
                if (!trialDiff[32]) begin
                    remReg <= trialDiff[31:0];
                    quoReg <= {quoReg[30:0], 1'b1};
                end else begin
                    remReg <= trial[31:0];
                    quoReg <= {quoReg[30:0], 1'b0};
                end
            end
            FIX: begin
                // remainder follows the dividend sign
                result_o[63:32] <= negRem ? -remReg : remReg;
                result_o[31:0]  <= negQuo ? -quoReg : quoReg;
            end
            default: ;
        endcase
    end

endmodule

/* hw/seqMultiplier.sv */
module seqMultiplier #(
    parameter int unsigned MUL_LATENCY = 3
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        start_i,
    input  logic        signed_i,
    input  logic [31:0] opA_i,
    input  logic [31:0] opB_i,
    output logic        ready_o,
    output logic [63:0] result_o
);

    logic signed [32:0] opAExt;
    logic signed [32:0] opBExt;
    logic signed [65:0] product;
    logic               busy;
    logic               launch;
    logic [MUL_LATENCY-1:0] validPipe;
    logic [63:0]        resultPipe [MUL_LATENCY];

    // one extra bit selects signed or unsigned product
    assign opAExt  = {signed_i & opA_i[31], opA_i};
    assign opBExt  = {signed_i & opB_i[31], opB_i};
    assign product = opAExt * opBExt;

    // a held start only launches once per operation
    assign launch = start_i && !busy;

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            busy      <= 1'b0;
            validPipe <= '0;
        end else begin
            if (launch) begin
                busy <= 1'b1;
            end else if (ready_o) begin
                busy <= 1'b0;
            end
            validPipe[0] <= launch;
            for (int k = 1; k < MUL_LATENCY; k++) begin
                validPipe[k] <= validPipe[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            resultPipe[0] <= product[63:0];
        end
        for (int k = 1; k < MUL_LATENCY; k++) begin
            resultPipe[k] <= resultPipe[k-1];
        end
    end

    assign ready_o  = validPipe[MUL_LATENCY-1];
    assign result_o = resultPipe[MUL_LATENCY-1];

endmodule

/* verification/execUnitTb.sv */
module execUnitTb import aluPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned MUL_LATENCY = 3;
    localparam int RESET_CYCLES = 10;
    localparam int DIV_CYCLES = 34;
    localparam int SINGLE_TESTS = 200;
    localparam int MUL_TESTS = 30;
    localparam int DIV_TESTS = 12;
    // two reads follow each multiply or divide and the directed ops add some more
    localparam int TOTAL_OPS = SINGLE_TESTS + 3 * MUL_TESTS + 3 * DIV_TESTS + 40;

    logic      clk;
    logic      rst;
    execReq_t  req;
    logic      flush;
    logic      flushExc;
    execResp_t resp;
    logic      stall;

    execResp_t   expResp;
    logic        expStall;
    logic        checkEn;
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [31:0] lcgState;

    execUnit #(
        .MUL_LATENCY(MUL_LATENCY)
    ) dut0 (
        .clk        (clk),
        .rst_i      (rst),
        .req_i      (req),
        .flush_i    (flush),
        .flushExc_i (flushExc),
        .resp_o     (resp),
        .stall_o    (stall)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // edge values turn up in about three draws out of eight
    function automatic logic [31:0] pickOperand();
        logic [31:0] r;
        r = nextRand();
        case (r[31:29])
            3'd0: return 32'd0;
            3'd1: return 32'hffff_ffff;
            3'd2: return 32'h8000_0000;
            default: return nextRand();
        endcase
    endfunction

    function automatic execReq_t makeReq(input aluOp_e op, input logic [31:0] a,
                                         input logic [31:0] b, input logic [4:0] sa);
        execReq_t r;
        r.op = op;
        r.srcA = a;
        r.srcB = b;
        r.sa = sa;
        return r;
    endfunction

    function automatic logic [31:0] countLead(input logic [31:0] v, input logic bitVal);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == bitVal) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] shiftArith(input logic [31:0] v, input logic [4:0] s);
        logic [31:0] fill;
        fill = v[31] ? ~(32'hffff_ffff >> s) : 32'd0;
        return (v >> s) | fill;
    endfunction

    // expected single-cycle response with HI/LO from the model
    function automatic execResp_t modelResp(input execReq_t r);
        execResp_t   e;
        logic [32:0] wide;
        logic [31:0] a;
        logic [31:0] b;
        a = r.srcA;
        b = r.srcB;
        e = '0;
        case (r.op)
            OP_NOP:  e.result = a;
            OP_AND:  e.result = a & b;
            OP_OR:   e.result = a | b;
            OP_NOR:  e.result = ~(a | b);
            OP_XOR:  e.result = a ^ b;
            OP_ADD, OP_ADDU: begin
                wide = {a[31], a} + {b[31], b};
                e.result = wide[31:0];
                e.overflow = (r.op == OP_ADD) && (wide[32] != wide[31]);
            end
            OP_SUB, OP_SUBU: begin
                wide = {a[31], a} - {b[31], b};
                e.result = wide[31:0];
                e.overflow = (r.op == OP_SUB) && (wide[32] != wide[31]);
            end
            OP_SLT:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: e.result = (a < b) ? 32'd1 : 32'd0;
            OP_SLLV: e.result = b << a[4:0];
            OP_SRLV: e.result = b >> a[4:0];
            OP_SRAV: e.result = shiftArith(b, a[4:0]);
            OP_SLL:  e.result = b << r.sa;
            OP_SRL:  e.result = b >> r.sa;
            OP_SRA:  e.result = shiftArith(b, r.sa);
            OP_LUI:  e.result = b << 16;
            OP_CLO:  e.result = countLead(a, 1'b1);
            OP_CLZ:  e.result = countLead(a, 1'b0);
            OP_MOVN: e.result = (b != 32'd0) ? a : 32'd0;
            OP_MOVZ: e.result = (b == 32'd0) ? a : 32'd0;
            OP_MFHI: e.result = modelHi;
            OP_MFLO: e.result = modelLo;
            OP_TEQ:  e.trap = (a == b);
            OP_TNE:  e.trap = (a != b);
            OP_TGE:  e.trap = !($signed(a) < $signed(b));
            OP_TGEU: e.trap = !(a < b);
            OP_TLT:  e.trap = ($signed(a) < $signed(b));
            OP_TLTU: e.trap = (a < b);
            default: ;
        endcase
        return e;
    endfunction

    function automatic logic [63:0] productOf(input execReq_t r);
        logic [63:0] a64;
        logic [63:0] b64;
        if (r.op == OP_MULT || r.op == OP_MUL || r.op == OP_MADD || r.op == OP_MSUB) begin
            a64 = {{32{r.srcA[31]}}, r.srcA};
            b64 = {{32{r.srcB[31]}}, r.srcB};
        end else begin
            a64 = {32'd0, r.srcA};
            b64 = {32'd0, r.srcB};
        end
        return a64 * b64;
    endfunction

    // remainder in the upper word and quotient in the lower word
    function automatic logic [63:0] divideOf(input execReq_t r);
        logic        sgn;
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] rm;
        sgn = (r.op == OP_DIV);
        ma = (sgn && r.srcA[31]) ? -r.srcA : r.srcA;
        mb = (sgn && r.srcB[31]) ? -r.srcB : r.srcB;
        q = ma / mb;
        rm = ma % mb;
        if (sgn && (r.srcA[31] != r.srcB[31])) begin
            q = -q;
        end
        if (sgn && r.srcA[31]) begin
            rm = -rm;
        end
        return {rm, q};
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
        $display("Error: %s is 0x%0h, expected 0x%0h", name, got, want);
        $display("ERRORS FOUND");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic runSingle(input execReq_t r, input logic exc);
        @(posedge clk);
        req      <= r;
        flushExc <= exc;
        expResp  <= modelResp(r);
        expStall <= 1'b0;
        // move-to writes land at the end of this cycle
        if (!exc && r.op == OP_MTHI) begin
            modelHi = r.srcA;
        end
        if (!exc && r.op == OP_MTLO) begin
            modelLo = r.srcA;
        end
    endtask

    task automatic readHiLo();
        runSingle(makeReq(OP_MFHI, 32'd0, 32'd0, 5'd0), 1'b0);
        runSingle(makeReq(OP_MFLO, 32'd0, 32'd0, 5'd0), 1'b0);
    endtask

    // exc raises flushExc_i in the ready cycle of the multiply or divide
    task automatic runLong(input execReq_t r, input logic exc);
        logic [63:0] prod;
        logic [63:0] newHiLo;
        int          cycles;
        cycles = (r.op == OP_DIV || r.op == OP_DIVU) ? DIV_CYCLES : MUL_LATENCY;
        prod = productOf(r);
        case (r.op)
            OP_MADD, OP_MADDU: newHiLo = {modelHi, modelLo} + prod;
            OP_MSUB, OP_MSUBU: newHiLo = {modelHi, modelLo} - prod;
            OP_DIV, OP_DIVU:   newHiLo = divideOf(r);
            default:           newHiLo = prod;
        endcase
        @(posedge clk);
        req      <= r;
        flushExc <= 1'b0;
        expResp  <= '0;
        expStall <= 1'b1;
        repeat (cycles) @(posedge clk);
        // ready cycle
        expStall       <= 1'b0;
        expResp.result <= (r.op == OP_MUL) ? prod[31:0] : 32'd0;
        flushExc       <= exc;
        if (!exc) begin
            modelHi = newHiLo[63:32];
            modelLo = newHiLo[31:0];
        end
    endtask

    task automatic runDivFlush(input execReq_t r);
        @(posedge clk);
        req      <= r;
        flushExc <= 1'b0;
        expResp  <= '0;
        expStall <= 1'b1;
        repeat (5) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        // divider back in idle and the op withdrawn
        flush    <= 1'b0;
        req      <= makeReq(OP_NOP, 32'd0, 32'd0, 5'd0);
        expResp  <= '0;
        expStall <= 1'b0;
    endtask

    assert property (@(negedge clk) disable iff (!checkEn) resp.result == expResp.result)
        else reportMismatch("resp_o.result", resp.result, expResp.result);
    assert property (@(negedge clk) disable iff (!checkEn) resp.overflow == expResp.overflow)
        else reportMismatch("resp_o.overflow", resp.overflow, expResp.overflow);
    assert property (@(negedge clk) disable iff (!checkEn) resp.trap == expResp.trap)
        else reportMismatch("resp_o.trap", resp.trap, expResp.trap);
    assert property (@(negedge clk) disable iff (!checkEn) stall == expStall)
        else reportMismatch("stall_o", stall, expStall);

    initial begin
        repeat (RESET_CYCLES + TOTAL_OPS * (DIV_CYCLES + 5)) @(posedge clk);
        $display("Timeout: the tests did not finish in the allowed number of cycles");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        execReq_t r;
        int       code;
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        flush = 1'b0;
        flushExc = 1'b0;
        expResp = '0;
        expStall = 1'b0;
        checkEn = 1'b0;
        modelHi = 32'd0;
        modelLo = 32'd0;
        lcgState = 32'd73;
        repeat (RESET_CYCLES) @(posedge clk);
        rst     <= 1'b0;
        checkEn <= 1'b1;

        // HI/LO straight after reset
        readHiLo();
        runSingle(makeReq(OP_ADD, 32'h7fff_ffff, 32'd1, 5'd0), 1'b0);
        runSingle(makeReq(OP_ADD, 32'h8000_0000, 32'h8000_0000, 5'd0), 1'b0);
        runSingle(makeReq(OP_SUB, 32'h8000_0000, 32'd1, 5'd0), 1'b0);
        runSingle(makeReq(OP_CLO, 32'hffff_ffff, 32'd0, 5'd0), 1'b0);
        runSingle(makeReq(OP_CLO, 32'd0, 32'd0, 5'd0), 1'b0);
        runSingle(makeReq(OP_CLZ, 32'd0, 32'd0, 5'd0), 1'b0);
        runSingle(makeReq(OP_CLZ, 32'h8000_0000, 32'd0, 5'd0), 1'b0);

        for (int i = 0; i < SINGLE_TESTS; i++) begin
            code = (nextRand() >> 8) % 28;
            r.op = (code < 22) ? aluOp_e'(code) : aluOp_e'(int'(OP_TEQ) + code - 22);
            r.srcA = pickOperand();
            r.srcB = pickOperand();
            r.sa = 5'(nextRand() >> 27);
            runSingle(r, 1'b0);
        end

        for (int i = 0; i < MUL_TESTS; i++) begin
            r.op = aluOp_e'(int'(OP_MULT) + ((nextRand() >> 8) % 7));
            r.srcA = pickOperand();
            r.srcB = pickOperand();
            r.sa = 5'd0;
            runLong(r, 1'b0);
            readHiLo();
        end

        for (int i = 0; i < DIV_TESTS; i++) begin
            r.op = (((nextRand() >> 8) % 2) == 0) ? OP_DIV : OP_DIVU;
            r.srcA = pickOperand();
            r.srcB = pickOperand();
            r.sa = 5'd0;
            if (r.srcB == 32'd0) begin
                r.srcB = 32'd7;
            end
            runLong(r, 1'b0);
            readHiLo();
        end

        // move-to writes touch one half only
        // nonzero LO ahead of the MTHI
        runSingle(makeReq(OP_MTLO, 32'h5a5a_0002, 32'd0, 5'd0), 1'b0);
        runSingle(makeReq(OP_MTHI, 32'hcafe_0001, 32'd0, 5'd0), 1'b0);
        readHiLo();
        runSingle(makeReq(OP_MTLO, 32'h1234_5678, 32'd0, 5'd0), 1'b0);
        readHiLo();

        // exception flush blocks the HI/LO write
        runSingle(makeReq(OP_MTHI, 32'h0bad_f00d, 32'd0, 5'd0), 1'b1);
        readHiLo();
        runLong(makeReq(OP_MADD, 32'h0001_0000, 32'h0003_0000, 5'd0), 1'b1);
        readHiLo();

        // pipeline flush mid divide and then a full divide from idle
        runDivFlush(makeReq(OP_DIV, 32'h7654_3210, 32'h0000_0123, 5'd0));
        readHiLo();
        runLong(makeReq(OP_DIV, 32'h8765_4321, 32'h0000_0456, 5'd0), 1'b0);
        readHiLo();
        runSingle(makeReq(OP_NOP, 32'd0, 32'd0, 5'd0), 1'b0);

        repeat (2) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* verilog.f */
hw/aluPkg.sv
hw/seqMultiplier.sv
hw/seqDivider.sv
hw/intAlu.sv
hw/hiLoReg.sv
hw/mulDivCtrl.sv
hw/execUnit.sv
verification/execUnitTb.sv
